// File: verilog.f
+incdir+sim
design/paillier_pkg.sv
design/uart_rx.sv
design/lfsr32.sv
design/mod_mult.sv
design/mod_exp.sv
design/vote_encryptor.sv
design/spi_tx.sv
design/ballot_encryptor_top.sv
sim/tb_ballot_encryptor.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ballot_encryptor
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= >>> PASS

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard design/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// model copy of the random source, follows the DUT LFSR from reset
logic [31:0] ref_lfsr = lfsr_seed;

// one Galois step, the mask folds in when a one drops out of the lsb
function automatic logic [31:0] lfsr_next(input logic [31:0] w);
  logic [31:0] nxt;
  nxt = w >> 1;
  if (w[0]) begin
    nxt = nxt ^ lfsr_taps;
  end
  return nxt;
endfunction

// step until the low half is a usable r in 1..n-1
function automatic logic [15:0] draw_r(input longint unsigned n);
  logic [15:0] low;
  ref_lfsr = lfsr_next(ref_lfsr);
  low = ref_lfsr[15:0];
  while (low == 16'd0 || 64'(low) >= n) begin
    ref_lfsr = lfsr_next(ref_lfsr);
    low = ref_lfsr[15:0];
  end
  return low;
endfunction

// right to left binary power
function automatic ct_word_t pow_mod(input longint unsigned base, input longint unsigned e,
                                     input longint unsigned m);
  longint unsigned acc;
  longint unsigned b;
  acc = 64'd1;
  b = base % m;
  while (e != 64'd0) begin
    if (e[0]) begin
      acc = (acc * b) % m;
    end
    b = (b * b) % m;
    e = e >> 1;
  end
  return ct_word_t'(acc);
endfunction

// c = (1 + m*n) * r^n mod n^2, with g = n + 1
function automatic ct_word_t ciphertext(input logic [7:0] m, input logic [15:0] r,
                                        input longint unsigned n);
  longint unsigned nsq;
  longint unsigned gm;
  longint unsigned rn;
  nsq = n * n;
  gm = (64'd1 + 64'(m) * n) % nsq;
  rn = 64'(pow_mod(64'(r), n, nsq));
  return ct_word_t'((gm * rn) % nsq);
endfunction

`endif

// File: sim/tb_ballot_encryptor.sv
`timescale 1ns/1ps

module tb_ballot_encryptor;

  import paillier_pkg::*;

  localparam int key_n = 40427;
  localparam int clks_per_bit = 16;
  localparam int spi_half_period = 8;
  localparam int num_random = 20;
  // every byte put on the line including dropped ones
  localparam int num_bytes = 1 + 2 + num_random + 2 + 2;
  localparam int max_gap = 64;
  localparam int uart_frame_cycles = 10 * clks_per_bit;
  // square and multiply on each key bit plus the g^m product and a few redraws
  localparam int worst_enc_cycles = 1 + key_w * 68 + 34 + 64;
  localparam int spi_frame_cycles = 2 * spi_half_period * ct_w + 4;
  localparam int cycle_limit =
    num_bytes * (uart_frame_cycles + worst_enc_cycles + spi_frame_cycles + max_gap) * 2;
  localparam longint unsigned n_model = 64'(key_n);
  localparam longint unsigned n_sq_model = n_model * n_model;

  logic clk_100mhz;
  logic sys_rst;
  logic uart_rxd;
  logic copi;
  logic dclk;
  logic cs;
  logic busy;

  ct_word_t exp_q[$];
  ct_word_t frame_q[$];
  int       frames_checked = 0;
  int       sent_votes = 0;
  int       cycle_cnt = 0;
  int       seed = 97;

  `include "tb_ref.svh"

  ballot_encryptor_top #(
    .KEY_N(key_n),
    .CLKS_PER_BIT(clks_per_bit),
    .SPI_HALF_PERIOD(spi_half_period)
  ) uut (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .uart_rxd(uart_rxd),
    .copi(copi),
    .dclk(dclk),
    .cs(cs),
    .busy(busy)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_ct(input string name, input ct_word_t got, input ct_word_t want);
    if (got !== want) begin
      report_fail($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, want, got));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      report_fail($sformatf("mismatch at %0t: %s expected %b got %b", $time, name, want, got));
    end
  endtask

  task automatic expect_idle();
    check_bit("cs", cs, 1'b1);
    check_bit("dclk", dclk, 1'b0);
    check_bit("copi", copi, 1'b0);
    check_bit("busy", busy, 1'b0);
  endtask

  // holds the level for one bit time from a rising edge
  task automatic hold_rx_bit(input logic level);
    uart_rxd <= level;
    repeat (clks_per_bit) @(posedge clk_100mhz);
  endtask

  // 8N1 frame with lsb first
  task automatic uart_send(input logic [7:0] data, input logic bad_stop);
    @(posedge clk_100mhz);
    hold_rx_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      hold_rx_bit(data[i]);
    end
    hold_rx_bit(~bad_stop);
    if (bad_stop) begin
      hold_rx_bit(1'b1);
    end
  endtask

  task automatic cast_vote(input logic [7:0] m);
    logic [15:0] r;
    r = draw_r(n_model);
    // vote 0 leaves only the r^n term
    if (m == 8'd0) begin
      exp_q.push_back(pow_mod(64'(r), n_model, n_sq_model));
    end else begin
      exp_q.push_back(ciphertext(m, r, n_model));
    end
    sent_votes++;
    uart_send(m, 1'b0);
  endtask

  task automatic wait_frames(input int count);
    while (frames_checked < count) begin
      @(posedge clk_100mhz);
    end
  endtask

  // one frame per cs low period with copi sampled on rising dclk
  initial begin : spi_monitor
    ct_word_t word;
    forever begin
      @(negedge cs);
      word = '0;
      for (int i = 0; i < ct_w; i++) begin
        @(posedge dclk);
        check_bit("cs", cs, 1'b0);
        word = {word[ct_w-2:0], copi};
      end
      @(posedge cs);
      frame_q.push_back(word);
    end
  end

  initial begin : comparer
    ct_word_t got;
    ct_word_t want;
    forever begin
      @(posedge clk_100mhz);
      if (frame_q.size() != 0) begin
        got = frame_q.pop_front();
        if (exp_q.size() == 0) begin
          report_fail($sformatf("frame %h arrived at %0t with no vote pending", got, $time));
        end else begin
          want = exp_q.pop_front();
          check_ct("ct frame", got, want);
          frames_checked++;
        end
      end
    end
  end

  initial begin : watchdog
    forever begin
      @(posedge clk_100mhz);
      cycle_cnt++;
      if (cycle_cnt >= cycle_limit) begin
        report_fail($sformatf("timeout after %0d cycles waiting for the DUT", cycle_cnt));
      end
    end
  end

  initial begin : stimulus
    logic [7:0] vote;
    int         gap;
    sys_rst <= 1'b1;
    uart_rxd <= 1'b1;
    repeat (10) @(posedge clk_100mhz);
    sys_rst <= 1'b0;

    // lines stay quiet until the first byte
    repeat (20) begin
      @(negedge clk_100mhz);
      expect_idle();
    end

    cast_vote(8'd1);
    wait_frames(sent_votes);

    // both ends of the byte range
    cast_vote(8'd0);
    wait_frames(sent_votes);
    cast_vote(8'd255);
    wait_frames(sent_votes);

    // lfsr state and redraws carry over between votes
    for (int k = 0; k < num_random; k++) begin
      vote = 8'($random(seed));
      gap = int'({$random(seed)} % max_gap);
      repeat (gap) @(posedge clk_100mhz);
      cast_vote(vote);
      wait_frames(sent_votes);
    end

    // second byte lands while the first is still encrypting
    cast_vote(8'd42);
    uart_send(8'd77, 1'b0);
    @(negedge clk_100mhz);
    check_bit("busy", busy, 1'b1);
    wait_frames(sent_votes);

    // framing error followed by a good vote
    uart_send(8'd9, 1'b1);
    repeat (4) @(negedge clk_100mhz);
    check_bit("busy", busy, 1'b0);
    cast_vote(8'd9);
    wait_frames(sent_votes);

    repeat (50) @(negedge clk_100mhz);
    expect_idle();
    if (exp_q.size() != 0 || frame_q.size() != 0) begin
      report_fail($sformatf("run ended with %0d votes unanswered and %0d frames unchecked",
                            exp_q.size(), frame_q.size()));
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// File: design/ballot_encryptor_top.sv
`timescale 1ns/1ps

module ballot_encryptor_top #(
  parameter int KEY_N = 40427,
  parameter int CLKS_PER_BIT = 100000000 / 4800,
  parameter int SPI_HALF_PERIOD = 50
) (
  input  logic clk_100mhz,
  input  logic sys_rst,
  input  logic uart_rxd,
  output logic copi,
  output logic dclk,
  output logic cs,
  output logic busy
);

  import paillier_pkg::*;

  logic       byte_valid;
  logic [7:0] rx_byte;
  logic       ct_valid;
  ct_word_t   ct;
  logic       spi_busy;

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) vote_rx (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .rxd(uart_rxd),
    .byte_valid(byte_valid),
    .rx_byte(rx_byte)
  );

  vote_encryptor #(
    .KEY_N(KEY_N)
  ) encryptor (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .byte_valid(byte_valid),
    .rx_byte(rx_byte),
    .spi_busy(spi_busy),
    .ct_valid(ct_valid),
    .ct(ct),
    .busy(busy)
  );

  // ciphertext out to the tally side
  spi_tx #(
    .SPI_HALF_PERIOD(SPI_HALF_PERIOD)
  ) ct_tx (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .ct_valid(ct_valid),
    .ct(ct),
    .spi_busy(spi_busy),
    .copi(copi),
    .dclk(dclk),
    .cs(cs)
  );

endmodule

// File: design/spi_tx.sv
`timescale 1ns/1ps

module spi_tx #(
  parameter int SPI_HALF_PERIOD = 50
) (
  input  logic                   clk_100mhz,
  input  logic                   sys_rst,
  input  logic                   ct_valid,
  input  paillier_pkg::ct_word_t ct,
  output logic                   spi_busy,
  output logic                   copi,
  output logic                   dclk,
  output logic                   cs
);

  import paillier_pkg::*;

  localparam int half_w = $clog2(SPI_HALF_PERIOD + 1);
  localparam int bit_w = $clog2(ct_w);

  ct_word_t          shreg;
  logic [half_w-1:0] half_cnt;
  logic [bit_w-1:0]  bit_cnt;
  logic              half_tick;
  logic              fall_tick;

  assign half_tick = (half_cnt == half_w'(SPI_HALF_PERIOD - 1));
  // dclk is high, so this toggle is a falling edge
  assign fall_tick = spi_busy && half_tick && dclk;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      spi_busy <= 1'b0;
      cs <= 1'b1;
      dclk <= 1'b0;
      copi <= 1'b0;
      half_cnt <= '0;
      bit_cnt <= '0;
    end else if (!spi_busy) begin
      if (ct_valid) begin
        spi_busy <= 1'b1;
        cs <= 1'b0;
        copi <= ct[ct_w-1];
        half_cnt <= '0;
        bit_cnt <= '0;
      end
    end else begin
      half_cnt <= half_tick ? '0 : half_cnt + 1'b1;
      if (half_tick) begin
        dclk <= ~dclk;
      end
      if (fall_tick) begin
        if (bit_cnt == bit_w'(ct_w - 1)) begin
          // last bit done, end the frame
          spi_busy <= 1'b0;
          cs <= 1'b1;
          copi <= 1'b0;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
          copi <= shreg[ct_w-2];
        end
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (!spi_busy && ct_valid) begin
      shreg <= ct;
    end else if (fall_tick) begin
      shreg <= {shreg[ct_w-2:0], 1'b0};
    end
  end

endmodule

// File: design/vote_encryptor.sv
`timescale 1ns/1ps

module vote_encryptor #(
  parameter int KEY_N = 40427
) (
  input  logic                   clk_100mhz,
  input  logic                   sys_rst,
  input  logic                   byte_valid,
  input  logic [7:0]             rx_byte,
  input  logic                   spi_busy,
  output logic                   ct_valid,
  output paillier_pkg::ct_word_t ct,
  output logic                   busy
);

  import paillier_pkg::*;

  localparam logic [key_w-1:0] n_key = key_w'(KEY_N);
  localparam ct_word_t n_word = ct_word_t'(KEY_N);
  localparam ct_word_t n_sq = n_word * n_word;

  typedef enum logic [2:0] {
    st_idle,
    st_draw,
    st_exp,
    st_mul,
    st_send
  } enc_state_t;

  enc_state_t state;
  logic [7:0] m_reg;
  ct_word_t   factor;
  ct_word_t   mn_sum;
  logic       lfsr_step;
  logic [31:0] rand_word;
  logic       draw_ok;
  logic       exp_start;
  ct_word_t   exp_result;
  logic       exp_done;
  logic       mul_start;
  mul_req_t   mul_req;
  logic       mul_done;

  // r must lie in 1..n-1
  assign draw_ok = (rand_word[key_w-1:0] != '0) && (rand_word[key_w-1:0] < n_key);
  assign lfsr_step = (state == st_idle && byte_valid) || (state == st_draw && !draw_ok);
  assign exp_start = (state == st_draw) && draw_ok;
  assign mul_start = (state == st_exp) && exp_done;
  assign ct_valid = (state == st_send) && !spi_busy;
  assign busy = (state != st_idle);

  // m*n by shift-add, m < n keeps 1 + m*n below n squared
  always_comb begin
    mn_sum = '0;
    for (int i = 0; i < 8; i++) begin
      if (m_reg[i]) begin
        mn_sum = mn_sum + (n_word << i);
      end
    end
  end

  always_comb begin
    mul_req.a = exp_result;
    mul_req.b = factor;
  end

  lfsr32 rng (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .step(lfsr_step),
    .rand_word(rand_word)
  );

  // r^n mod n^2
  mod_exp #(
    .MOD(n_sq)
  ) expo (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .start(exp_start),
    .base(ct_word_t'(rand_word[key_w-1:0])),
    .exponent(n_key),
    .result(exp_result),
    .done(exp_done)
  );

  // product holds until the next vote, so it serves as the frame word
  mod_mult #(
    .MOD(n_sq)
  ) gm_mult (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .start(mul_start),
    .req(mul_req),
    .product(ct),
    .done(mul_done)
  );

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (byte_valid) state <= st_draw;
        st_draw: if (draw_ok) state <= st_exp;
        st_exp: if (exp_done) state <= st_mul;
        st_mul: if (mul_done) state <= st_send;
        st_send: if (!spi_busy) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (state == st_idle && byte_valid) begin
      m_reg <= rx_byte;
    end
    if (exp_start) begin
      factor <= mn_sum + ct_word_t'(1);
    end
  end

endmodule

// File: design/mod_exp.sv
`timescale 1ns/1ps

module mod_exp #(
  parameter paillier_pkg::ct_word_t MOD = 32'd1634342329
) (
  input  logic                   clk_100mhz,
  input  logic                   sys_rst,
  input  logic                   start,
  input  paillier_pkg::ct_word_t base,
  input  logic [15:0]            exponent,
  output paillier_pkg::ct_word_t result,
  output logic                   done
);

  import paillier_pkg::*;

  localparam int bit_w = $clog2(key_w);

  typedef enum logic [2:0] {
    st_idle,
    st_issue_sq,
    st_wait_sq,
    st_issue_mul,
    st_wait_mul
  } exp_state_t;

  exp_state_t       state;
  ct_word_t         base_reg;
  logic [key_w-1:0] exp_reg;
  logic [bit_w-1:0] bit_cnt;
  logic             mul_start;
  mul_req_t         mul_req;
  ct_word_t         mul_product;
  logic             mul_done;
  logic             next_bit;

  // squares use the running value twice, multiplies pair it with the base
  always_comb begin
    mul_start = (state == st_issue_sq) || (state == st_issue_mul);
    mul_req.a = result;
    mul_req.b = (state == st_issue_mul) ? base_reg : result;
  end

  // current exponent bit finished
  assign next_bit = mul_done &&
                    ((state == st_wait_sq && !exp_reg[key_w-1]) || state == st_wait_mul);

  mod_mult #(
    .MOD(MOD)
  ) mult (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .start(mul_start),
    .req(mul_req),
    .product(mul_product),
    .done(mul_done)
  );

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      state <= st_idle;
      bit_cnt <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            bit_cnt <= '0;
            state <= st_issue_sq;
          end
        end
        st_issue_sq: state <= st_wait_sq;
        st_wait_sq: begin
          if (mul_done && exp_reg[key_w-1]) begin
            state <= st_issue_mul;
          end
        end
        st_issue_mul: state <= st_wait_mul;
        st_wait_mul: ;
        default: state <= st_idle;
      endcase
      if (next_bit) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == bit_w'(key_w - 1)) begin
          done <= 1'b1;
          state <= st_idle;
        end else begin
          state <= st_issue_sq;
        end
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (state == st_idle && start) begin
      base_reg <= base;
      exp_reg <= exponent;
      result <= ct_word_t'(1);
    end else begin
      if (mul_done) begin
        result <= mul_product;
      end
      if (next_bit) begin
        exp_reg <= {exp_reg[key_w-2:0], 1'b0};
      end
    end
  end

endmodule

// File: design/mod_mult.sv
`timescale 1ns/1ps

module mod_mult #(
  parameter paillier_pkg::ct_word_t MOD = 32'd1634342329
) (
  input  logic                   clk_100mhz,
  input  logic                   sys_rst,
  input  logic                   start,
  input  paillier_pkg::mul_req_t req,
  output paillier_pkg::ct_word_t product,
  output logic                   done
);

  import paillier_pkg::*;

  localparam int cnt_w = $clog2(ct_w);
  localparam logic [ct_w+1:0] mod_ext = {2'b00, MOD};

  ct_word_t         a_reg;
  ct_word_t         b_reg;
  logic             running;
  logic [cnt_w-1:0] bit_cnt;
  logic [ct_w+1:0]  sum;
  logic [ct_w+1:0]  red1;
  logic [ct_w+1:0]  red2;

  // 2*acc + a stays below 3*MOD, so two subtractions bring it back in range
  always_comb begin
    sum = {1'b0, product, 1'b0};
    if (b_reg[ct_w-1]) begin
      sum = sum + {2'b00, a_reg};
    end
    red1 = (sum >= mod_ext) ? sum - mod_ext : sum;
    red2 = (red1 >= mod_ext) ? red1 - mod_ext : red1;
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      running <= 1'b0;
      done <= 1'b0;
      bit_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        running <= 1'b1;
        bit_cnt <= '0;
      end else if (running) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == cnt_w'(ct_w - 1)) begin
          running <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // operands and accumulator, b scanned from the msb
  always_ff @(posedge clk_100mhz) begin
    if (start) begin
      a_reg <= req.a;
      b_reg <= req.b;
      product <= '0;
    end else if (running) begin
      product <= red2[ct_w-1:0];
      b_reg <= {b_reg[ct_w-2:0], 1'b0};
    end
  end

endmodule

// File: design/lfsr32.sv
`timescale 1ns/1ps

module lfsr32 (
  input  logic        clk_100mhz,
  input  logic        sys_rst,
  input  logic        step,
  output logic [31:0] rand_word
);

  import paillier_pkg::*;

  logic [31:0] next_word;

  // galois form, shift right and fold taps in when lsb is set
  always_comb begin
    next_word = {1'b0, rand_word[31:1]};
    if (rand_word[0]) begin
      next_word = next_word ^ lfsr_taps;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      rand_word <= lfsr_seed;
    end else if (step) begin
      rand_word <= next_word;
    end
  end

endmodule

// File: design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 100000000 / 4800
) (
  input  logic       clk_100mhz,
  input  logic       sys_rst,
  input  logic       rxd,
  output logic       byte_valid,
  output logic [7:0] rx_byte
);

  localparam int cnt_w = $clog2(CLKS_PER_BIT + 1);

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_data,
    st_stop,
    st_break
  } rx_state_t;

  rx_state_t        state;
  logic             rxd_meta;
  logic             rxd_sync;
  logic [cnt_w-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic             bit_done;
  logic             half_done;

  assign bit_done = (clk_cnt == cnt_w'(CLKS_PER_BIT - 1));
  assign half_done = (clk_cnt == cnt_w'(CLKS_PER_BIT / 2 - 1));

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      state <= st_idle;
      clk_cnt <= '0;
      bit_idx <= '0;
      byte_valid <= 1'b0;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      byte_valid <= 1'b0;
      case (state)
        st_idle: begin
          clk_cnt <= '0;
          if (!rxd_sync) begin
            state <= st_start;
          end
        end
        st_start: begin
          // recheck at start bit center, drop glitches
          if (half_done) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state <= rxd_sync ? st_idle : st_data;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        st_data: begin
          if (bit_done) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= st_stop;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        st_stop: begin
          if (bit_done) begin
            clk_cnt <= '0;
            if (rxd_sync) begin
              byte_valid <= 1'b1;
              state <= st_idle;
            end else begin
              state <= st_break;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        // framing error, wait for the line to go idle
        st_break: begin
          if (rxd_sync) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clk_100mhz) begin
    if (state == st_data && bit_done) begin
      rx_byte <= {rxd_sync, rx_byte[7:1]};
    end
  end

endmodule

// File: design/paillier_pkg.sv
package paillier_pkg;

  // key and ciphertext widths
  localparam int key_w = 16;
  localparam int ct_w = 32;

  // galois feedback mask, taps 32 22 2 1
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;
  // any nonzero start value works
  localparam logic [31:0] lfsr_seed = 32'h1d87_2b41;

  // one residue modulo n squared
  typedef logic [ct_w-1:0] ct_word_t;

  // operand pair for the modular multiplier
  typedef struct packed {
    ct_word_t a;
    ct_word_t b;
  } mul_req_t;

endpackage
